/* logic/tl_pkg.sv */
`default_nettype none

package tl_pkg;

	localparam int data_bytes = 4;

	typedef logic [31:0] addr_t;
	typedef logic [8*data_bytes-1:0] data_t;
	typedef logic [data_bytes-1:0] mask_t;

	// TL-UL plus the TL-UH codes, which only reach the error path
	typedef enum logic [2:0] {
		a_put_full    = 3'd0,
		a_put_partial = 3'd1,
		a_arithmetic  = 3'd2,
		a_logical     = 3'd3,
		a_get         = 3'd4,
		a_intent      = 3'd5
	} a_opcode_e;

	typedef enum logic [2:0] {
		d_access_ack      = 3'd0,
		d_access_ack_data = 3'd1,
		d_hint_ack        = 3'd2
	} d_opcode_e;

	typedef struct packed {
		a_opcode_e opcode;
		logic [2:0] param;
		logic [3:0] size; // log2 of bytes
		logic source;
		addr_t address;
		mask_t mask;
		data_t data;
	} tl_a_t;

	typedef struct packed {
		d_opcode_e opcode;
		logic [1:0] param;
		logic [3:0] size;
		logic source;
		logic sink;
		data_t data;
		logic error;
	} tl_d_t;

	typedef struct packed {
		logic atomic;
		logic readable;
		logic writable;
		logic executable;
		logic cacheable;
	} pma_attr_t;

	localparam logic [3:0] max_size = 4'd4; // 16 bytes, four beats

	typedef struct packed {
		addr_t base;
		addr_t limit; // first address past the region
		pma_attr_t attr;
	} region_t;

	localparam int num_regions = 7;

	localparam region_t pma_map [num_regions] = '{
		'{base: 32'h0000_0000, limit: 32'h0000_1000, attr: 5'b11110}, // debug
		'{base: 32'h0000_3000, limit: 32'h0000_4000, attr: 5'b11110}, // error device
		'{base: 32'h0001_0000, limit: 32'h0002_0000, attr: 5'b01011}, // rom
		'{base: 32'h0200_0000, limit: 32'h0201_0000, attr: 5'b11100}, // clint
		'{base: 32'h0c00_0000, limit: 32'h1000_0000, attr: 5'b11100}, // plic
		'{base: 32'h6000_0000, limit: 32'h8000_0000, attr: 5'b01110}, // mmio
		'{base: 32'h8000_0000, limit: 32'h8000_4000, attr: 5'b11110}  // dtim
	};

endpackage

`default_nettype wire

/* logic/reset_stretch.sv */
`timescale 1ns/10ps
`default_nettype none

module reset_stretch #(
	parameter int RESET_HOLD = 5
) (
	input wire clock,
	input wire reset,
	output logic core_reset
);

	localparam int cnt_w = $clog2(RESET_HOLD + 1);

	logic [cnt_w-1:0] hold_cnt;

	always_ff @(posedge clock) begin
		if (reset) begin
			hold_cnt <= cnt_w'(RESET_HOLD);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - cnt_w'(1);
		end
	end

	// Held until the count drains
	assign core_reset = reset || (hold_cnt != '0);

endmodule

`default_nettype wire

/* logic/pma_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module pma_checker (
	input wire tl_pkg::addr_t address,
	input wire [3:0] size,
	output tl_pkg::pma_attr_t attr
);

	tl_pkg::addr_t span_m1;
	tl_pkg::addr_t address_last;
	tl_pkg::pma_attr_t attr_first;
	tl_pkg::pma_attr_t attr_last;
	logic misaligned;

	// Attributes of the region holding one byte, none for a hole
	function automatic tl_pkg::pma_attr_t region_attr(input tl_pkg::addr_t addr);
		tl_pkg::pma_attr_t found;
		found = '0;
		for (int i = 0; i < tl_pkg::num_regions; i++) begin
			if (addr >= tl_pkg::pma_map[i].base && addr < tl_pkg::pma_map[i].limit) begin
				found = tl_pkg::pma_map[i].attr;
			end
		end
		return found;
	endfunction

	assign span_m1 = (32'd1 << size) - 32'd1;
	assign address_last = address + span_m1;

	always_comb begin
		attr_first = region_attr(address);
		attr_last = region_attr(address_last);

		// Both ends must sit in the same region
		attr = attr_first & attr_last;

		misaligned = (size >= 4'd1) && (size <= 4'd4) && ((address & span_m1) != '0);
		if (misaligned) begin
			attr.atomic = 1'b0;
			attr.readable = 1'b0;
			attr.writable = 1'b0;
			attr.cacheable = 1'b0; // executable survives
		end
	end

endmodule

`default_nettype wire

/* logic/beat_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module beat_ram #(
	parameter int RAM_WORDS = 256
) (
	input wire clock,
	input wire rd_en,
	input wire [$clog2(RAM_WORDS)-1:0] rd_index,
	output tl_pkg::data_t rd_data,
	input wire wr_en,
	input wire [$clog2(RAM_WORDS)-1:0] wr_index,
	input wire tl_pkg::mask_t wr_mask,
	input wire tl_pkg::data_t wr_data
);

	tl_pkg::data_t mem [RAM_WORDS];

	initial begin
		for (int i = 0; i < RAM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clock) begin
		if (wr_en) begin
			for (int lane = 0; lane < $bits(tl_pkg::mask_t); lane++) begin
				if (wr_mask[lane])
					mem[wr_index][8*lane +: 8] <= wr_data[8*lane +: 8];
			end
		end
		if (rd_en)
			rd_data <= mem[rd_index]; // Holds between reads
	end

endmodule

`default_nettype wire

/* logic/tl_slave_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module tl_slave_ctrl #(
	parameter int RAM_WORDS = 256,
	parameter int DATA_BYTES = tl_pkg::data_bytes
) (
	input wire clock,
	input wire core_reset,

	input wire a_valid,
	output logic a_ready,
	input wire tl_pkg::tl_a_t a_bits,

	output logic d_valid,
	input wire d_ready,
	output tl_pkg::tl_d_t d_bits,

	output tl_pkg::addr_t pma_address,
	output logic [3:0] pma_size,
	input wire tl_pkg::pma_attr_t pma_attr,

	output logic rd_en,
	output logic [$clog2(RAM_WORDS)-1:0] rd_index,
	input wire tl_pkg::data_t rd_data,
	output logic wr_en,
	output logic [$clog2(RAM_WORDS)-1:0] wr_index,
	output tl_pkg::mask_t wr_mask,
	output tl_pkg::data_t wr_data
);

	localparam int idx_w = $clog2(RAM_WORDS);
	localparam logic [3:0] beat_lg = 4'($clog2(DATA_BYTES));

	typedef enum logic {
		st_idle,
		st_resp
	} state_e;

	state_e state;
	tl_pkg::tl_d_t hdr_q;
	logic [3:0] beats_left; // beats after the current one
	logic zero_data;
	logic fresh_q;
	tl_pkg::data_t hold_q;
	logic [idx_w-1:0] index_q;

	logic a_xfer;
	logic d_xfer;
	logic last_beat;
	logic is_get;
	logic is_put;
	logic get_ok;
	logic put_ok;
	logic [idx_w-1:0] a_index;
	logic [3:0] a_beats_m1;
	tl_pkg::tl_d_t a_hdr;

	assign pma_address = a_bits.address;
	assign pma_size = a_bits.size;

	assign d_valid = (state == st_resp);
	assign d_xfer = d_valid && d_ready;
	assign last_beat = (beats_left == 4'd0);
	// Next request may enter as the last beat leaves
	assign a_ready = !core_reset && (state == st_idle || (d_xfer && last_beat));
	assign a_xfer = a_valid && a_ready;
	assign a_index = idx_w'(a_bits.address >> beat_lg);

	always_comb begin
		is_get = (a_bits.opcode == tl_pkg::a_get);
		is_put = (a_bits.opcode == tl_pkg::a_put_full) ||
			(a_bits.opcode == tl_pkg::a_put_partial);
		get_ok = is_get && pma_attr.readable && (a_bits.size <= tl_pkg::max_size);
		put_ok = is_put && pma_attr.writable && (a_bits.size <= beat_lg); // single beat only

		a_beats_m1 = 4'd0;
		if (get_ok && a_bits.size > beat_lg)
			a_beats_m1 = (4'd1 << (a_bits.size - beat_lg)) - 4'd1;

		// Unsupported opcodes fall through to an AccessAck with error
		a_hdr = '0;
		a_hdr.opcode = is_get ? tl_pkg::d_access_ack_data : tl_pkg::d_access_ack;
		a_hdr.size = a_bits.size;
		a_hdr.source = a_bits.source;
		a_hdr.error = !(get_ok || put_ok);
	end

	assign wr_en = a_xfer && put_ok;
	assign wr_index = a_index;
	assign wr_mask = a_bits.mask;
	assign wr_data = a_bits.data;

	assign rd_en = (a_xfer && get_ok) || (d_xfer && !last_beat);
	assign rd_index = a_xfer ? a_index : index_q + idx_w'(1);

	always_comb begin
		d_bits = hdr_q;
		if (!zero_data)
			d_bits.data = fresh_q ? rd_data : hold_q; // RAM output only valid once
	end

	always_ff @(posedge clock) begin
		if (core_reset) begin
			state <= st_idle;
			fresh_q <= 1'b0;
		end else begin
			if (a_xfer) begin
				state <= st_resp;
			end else if (d_xfer && last_beat) begin
				state <= st_idle;
			end
			fresh_q <= rd_en;
		end
	end

	always_ff @(posedge clock) begin
		if (a_xfer) begin
			hdr_q <= a_hdr;
			zero_data <= !get_ok;
			beats_left <= a_beats_m1;
		end else if (d_xfer && !last_beat) begin
			beats_left <= beats_left - 4'd1;
		end
		if (rd_en)
			index_q <= rd_index;
		if (fresh_q)
			hold_q <= rd_data;
	end

endmodule

`default_nettype wire

/* logic/tl_responder_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tl_responder_top #(
	parameter int RESET_HOLD = 5,
	parameter int RAM_WORDS = 256,
	parameter int DATA_BYTES = tl_pkg::data_bytes
) (
	input wire clock,
	input wire reset,

	input wire a_valid,
	output logic a_ready,
	input wire tl_pkg::tl_a_t a_bits,

	output logic d_valid,
	input wire d_ready,
	output tl_pkg::tl_d_t d_bits
);

	localparam int idx_w = $clog2(RAM_WORDS);

	logic core_reset;
	tl_pkg::addr_t pma_address;
	logic [3:0] pma_size;
	tl_pkg::pma_attr_t pma_attr;
	logic rd_en;
	logic [idx_w-1:0] rd_index;
	tl_pkg::data_t rd_data;
	logic wr_en;
	logic [idx_w-1:0] wr_index;
	tl_pkg::mask_t wr_mask;
	tl_pkg::data_t wr_data;

	reset_stretch #(
		.RESET_HOLD(RESET_HOLD)
	) u_reset_stretch (
		.clock     (clock),
		.reset     (reset),
		.core_reset(core_reset)
	);

	pma_checker u_pma_checker (
		.address(pma_address),
		.size   (pma_size),
		.attr   (pma_attr)
	);

	tl_slave_ctrl #(
		.RAM_WORDS (RAM_WORDS),
		.DATA_BYTES(DATA_BYTES)
	) u_tl_slave_ctrl (
		.clock      (clock),
		.core_reset (core_reset),
		.a_valid    (a_valid),
		.a_ready    (a_ready),
		.a_bits     (a_bits),
		.d_valid    (d_valid),
		.d_ready    (d_ready),
		.d_bits     (d_bits),
		.pma_address(pma_address),
		.pma_size   (pma_size),
		.pma_attr   (pma_attr),
		.rd_en      (rd_en),
		.rd_index   (rd_index),
		.rd_data    (rd_data),
		.wr_en      (wr_en),
		.wr_index   (wr_index),
		.wr_mask    (wr_mask),
		.wr_data    (wr_data)
	);

	beat_ram #(
		.RAM_WORDS(RAM_WORDS)
	) u_beat_ram (
		.clock   (clock),
		.rd_en   (rd_en),
		.rd_index(rd_index),
		.rd_data (rd_data),
		.wr_en   (wr_en),
		.wr_index(wr_index),
		.wr_mask (wr_mask),
		.wr_data (wr_data)
	);

endmodule

`default_nettype wire

/* bench/tl_slave_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module tl_slave_asserts (
	input wire clock,
	input wire core_reset,
	input wire idle,
	input wire a_valid,
	input wire a_ready,
	input wire d_valid,
	input wire d_ready,
	input wire tl_pkg::tl_d_t d_bits
);

	// A stalled beat keeps its payload
	assert property (@(posedge clock) disable iff (core_reset)
		d_valid && !d_ready |=> d_valid && $stable(d_bits))
		else $error("d_bits changed while D was stalled");

	// No beat without an accepted request
	assert property (@(posedge clock) disable iff (core_reset)
		idle && !(a_valid && a_ready) |=> !d_valid)
		else $error("d_valid rose with no request accepted");

	assert property (@(posedge clock)
		core_reset |=> !d_valid) // FSM leaves reset idle
		else $error("d_valid high after reset");

endmodule

bind tl_slave_ctrl tl_slave_asserts u_slave_asserts (
	.clock     (clock),
	.core_reset(core_reset),
	.idle      (state == st_idle),
	.a_valid   (a_valid),
	.a_ready   (a_ready),
	.d_valid   (d_valid),
	.d_ready   (d_ready),
	.d_bits    (d_bits)
);

`default_nettype wire

/* bench/tl_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module tl_tb;

	localparam int num_requests = 600;
	localparam int ram_words = 256;
	localparam int watchdog_ns = (num_requests * 20 + 40) * 10;

	logic clock;
	logic reset;
	logic a_valid;
	logic a_ready;
	tl_pkg::tl_a_t a_bits;
	logic d_valid;
	logic d_ready;
	tl_pkg::tl_d_t d_bits;

	logic [31:0] rng_state;
	tl_pkg::data_t ref_mem [ram_words];
	tl_pkg::tl_d_t exp_q [$];

	tl_responder_top u_tl_responder_top (
		.clock  (clock),
		.reset  (reset),
		.a_valid(a_valid),
		.a_ready(a_ready),
		.a_bits (a_bits),
		.d_valid(d_valid),
		.d_ready(d_ready),
		.d_bits (d_bits)
	);

	always #5 clock = ~clock;

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic value_error(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		stop_run($sformatf("mismatch at %0t: %s is 0x%0h, expected 0x%0h",
			$time, name, got, exp));
	endtask

	task automatic check_ready(input logic got, input logic exp, input string name);
		if (got !== exp)
			value_error(name, 32'(got), 32'(exp));
	endtask

	task automatic check_beat(input tl_pkg::tl_d_t got, input tl_pkg::tl_d_t exp);
		if (got.opcode !== exp.opcode)
			value_error("d_bits.opcode", 32'(got.opcode), 32'(exp.opcode));
		if (got.param !== exp.param)
			value_error("d_bits.param", 32'(got.param), 32'(exp.param));
		if (got.size !== exp.size)
			value_error("d_bits.size", 32'(got.size), 32'(exp.size));
		if (got.source !== exp.source)
			value_error("d_bits.source", 32'(got.source), 32'(exp.source));
		if (got.sink !== exp.sink)
			value_error("d_bits.sink", 32'(got.sink), 32'(exp.sink));
		if (got.error !== exp.error)
			value_error("d_bits.error", 32'(got.error), 32'(exp.error));
		if (got.data !== exp.data)
			value_error("d_bits.data", got.data, exp.data);
	endtask

	// Region index of one byte, -1 for a hole
	function automatic int region_of(input tl_pkg::addr_t addr);
		if (addr < 32'h0000_1000) return 0;
		if (addr >= 32'h0000_3000 && addr < 32'h0000_4000) return 1;
		if (addr >= 32'h0001_0000 && addr < 32'h0002_0000) return 2;
		if (addr >= 32'h0200_0000 && addr < 32'h0201_0000) return 3;
		if (addr >= 32'h0c00_0000 && addr < 32'h1000_0000) return 4;
		if (addr >= 32'h6000_0000 && addr < 32'h8000_0000) return 5;
		if (addr >= 32'h8000_0000 && addr < 32'h8000_4000) return 6;
		return -1;
	endfunction

	function automatic tl_pkg::pma_attr_t expected_attr(input tl_pkg::addr_t addr,
			input logic [3:0] size);
		tl_pkg::addr_t span;
		int first;
		int last;
		tl_pkg::pma_attr_t attr;
		span = 32'd1 << size;
		first = region_of(addr);
		last = region_of(addr + span - 32'd1);
		attr = '0;
		if (first >= 0 && first == last) begin
			case (first)
				2: attr = 5'b01011;
				3, 4: attr = 5'b11100;
				5: attr = 5'b01110;
				default: attr = 5'b11110;
			endcase
		end
		if (size >= 4'd1 && size <= 4'd4 && (addr & (span - 32'd1)) != 32'd0) begin
			attr.atomic = 1'b0;
			attr.readable = 1'b0;
			attr.writable = 1'b0;
			attr.cacheable = 1'b0;
		end
		return attr;
	endfunction

	function automatic tl_pkg::tl_a_t make_request();
		tl_pkg::tl_a_t req;
		logic [31:0] r_op;
		logic [31:0] r_size;
		logic [31:0] r_addr;
		tl_pkg::addr_t addr;
		int pick;
		req = '0;
		r_op = next_rand();
		r_size = next_rand();
		r_addr = next_rand();
		pick = int'(r_op % 32'd11);
		case (pick)
			0, 1, 2, 3: req.opcode = tl_pkg::a_get;
			4, 5: req.opcode = tl_pkg::a_put_full;
			6, 7: req.opcode = tl_pkg::a_put_partial;
			8: req.opcode = tl_pkg::a_arithmetic;
			9: req.opcode = tl_pkg::a_logical;
			default: req.opcode = tl_pkg::a_intent;
		endcase
		req.size = 4'(r_size % 32'd6);
		if ((pick >= 4 && pick <= 7) && r_size[8])
			req.size = 4'(r_size % 32'd3); // Puts mostly fit one beat
		case (r_addr[2:0])
			3'd0, 3'd1, 3'd2, 3'd3:
				addr = 32'h8000_0000 | {20'h0, r_addr[15:14], 2'b00, r_addr[23:16]};
			3'd4: addr = 32'h0001_0000 | {16'h0, r_addr[31:16]};
			3'd5: addr = 32'h6000_0000 | {16'h0, r_addr[31:16]};
			3'd6: addr = {20'h0, r_addr[31:20]};
			default: addr = r_addr[3] ? (32'h0000_5000 | {24'h0, r_addr[31:24]}) :
				(32'h8000_3ff0 | {28'h0, r_addr[27:24]});
		endcase
		if (r_addr[13:11] != 3'd0)
			addr = addr & ~((32'd1 << req.size) - 32'd1);
		req.address = addr;
		case (req.size)
			4'd0: req.mask = 4'b0001 << addr[1:0];
			4'd1: req.mask = 4'b0011 << {addr[1], 1'b0};
			default: req.mask = 4'b1111;
		endcase
		if (req.opcode == tl_pkg::a_put_partial)
			req.mask = 4'(next_rand());
		req.data = next_rand();
		req.source = r_op[31];
		return req;
	endfunction

	// Expected beats for one accepted request
	task automatic model_request(input tl_pkg::tl_a_t req);
		tl_pkg::pma_attr_t attr;
		tl_pkg::tl_d_t beat;
		int index;
		int beats;
		logic is_get;
		logic is_put;
		attr = expected_attr(req.address, req.size);
		is_get = (req.opcode == tl_pkg::a_get);
		is_put = (req.opcode == tl_pkg::a_put_full) || (req.opcode == tl_pkg::a_put_partial);
		index = int'((req.address >> 2) % 32'(ram_words));
		beat = '0;
		beat.size = req.size;
		beat.source = req.source;
		beat.opcode = is_get ? tl_pkg::d_access_ack_data : tl_pkg::d_access_ack;
		if (!is_get && !is_put) begin
			beat.error = 1'b1;
			exp_q.push_back(beat);
		end else if (is_get && (!attr.readable || req.size > 4'd4)) begin
			beat.error = 1'b1;
			exp_q.push_back(beat);
		end else if (is_put && (!attr.writable || req.size > 4'd2)) begin
			beat.error = 1'b1;
			exp_q.push_back(beat);
		end else if (is_put) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (req.mask[lane])
					ref_mem[index][8*lane +: 8] = req.data[8*lane +: 8];
			end
			exp_q.push_back(beat);
		end else begin
			beats = 1;
			for (int s = 2; s < int'(req.size); s++)
				beats = beats * 2;
			for (int k = 0; k < beats; k++) begin
				beat.data = ref_mem[(index + k) % ram_words];
				exp_q.push_back(beat);
			end
		end
	endtask

	initial begin
		#(watchdog_ns);
		stop_run("timeout: the responder stopped making progress");
	end

	initial begin
		int sent;
		logic req_live;
		logic exp_a_ready;
		tl_pkg::tl_d_t exp_beat;
		clock = 1'b0;
		reset = 1'b1;
		a_valid = 1'b0;
		a_bits = '0;
		d_ready = 1'b0;
		rng_state = 32'h7615f593;
		sent = 0;
		req_live = 1'b0;
		for (int i = 0; i < ram_words; i++)
			ref_mem[i] = '0;

		for (int i = 0; i < 8; i++) begin
			@(posedge clock);
			if (i == 7)
				reset <= 1'b0;
			@(negedge clock);
			check_ready(a_ready, 1'b0, "a_ready");
			check_ready(d_valid, 1'b0, "d_valid");
		end
		for (int k = 2; k <= 6; k++) begin // Stretch window, ready on the sixth cycle
			@(posedge clock);
			@(negedge clock);
			check_ready(a_ready, k == 6, "a_ready");
			check_ready(d_valid, 1'b0, "d_valid");
		end

		while (sent < num_requests || exp_q.size() != 0) begin
			@(posedge clock);
			d_ready <= (next_rand() & 32'h3) != 32'h0;
			if (!req_live) begin
				if (sent < num_requests && (next_rand() & 32'h7) != 32'h0) begin
					a_bits <= make_request();
					a_valid <= 1'b1;
					req_live = 1'b1;
				end else begin
					a_valid <= 1'b0;
				end
			end
			@(negedge clock);
			check_ready(d_valid, exp_q.size() != 0, "d_valid");
			exp_a_ready = (exp_q.size() == 0) || (exp_q.size() == 1 && d_valid && d_ready);
			check_ready(a_ready, exp_a_ready, "a_ready");
			if (d_valid && d_ready) begin
				exp_beat = exp_q.pop_front();
				check_beat(d_bits, exp_beat);
			end
			if (a_valid && a_ready) begin
				model_request(a_bits);
				sent++;
				req_live = 1'b0;
			end
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
logic/tl_pkg.sv
logic/reset_stretch.sv
logic/pma_checker.sv
logic/beat_ram.sv
logic/tl_slave_ctrl.sv
logic/tl_responder_top.sv
bench/tl_slave_asserts.sv
bench/tl_tb.sv

/* Makefile */
SIM_LOG := sim.log

.PHONY: all lint clean

all:
	verilator --binary --assert -j 0 --top-module tl_tb -f src.f -o tl_sim
	-./obj_dir/tl_sim > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@grep -q "Simulation PASSED" $(SIM_LOG)

lint:
	verilator --lint-only -Wall --top-module tl_responder_top \
		logic/tl_pkg.sv \
		logic/reset_stretch.sv \
		logic/pma_checker.sv \
		logic/beat_ram.sv \
		logic/tl_slave_ctrl.sv \
		logic/tl_responder_top.sv

clean:
	rm -rf obj_dir $(SIM_LOG)
